/* build.f */
hw/neuro_pkg.sv
hw/packet_dispatch.sv
hw/spiking_network.sv
hw/network_sink.sv
hw/neuro_top.sv
tb/neuro_checker.sv
tb/neuro_tb.sv

/* hw/network_sink.sv */
`timescale 1ns/1ps
`default_nettype none

module network_sink
    import neuro_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  net_ctrl_t          ctrl,
    output logic               net_ready,
    input  logic [NUM_OUT-1:0] net_out,
    input  logic               snk_ready,
    output logic               snk_valid,
    output pkt_t               snk
);

    typedef enum logic [2:0] {
        IDLE,
        RUNS,
        CLRD,
        SPKS,
        SYNC
    } sink_state_t;

    sink_state_t state;
    sink_state_t next_state;

    // steps executed but not yet reported, and the amount being reported
    run_t run_cnt;
    run_t runs;
    logic run_full;

    logic clr_pend;
    logic sync_pend;

    // spikes of the last step and the neuron currently offered on the stream
    logic [NUM_OUT-1:0] fires;
    spk_idx_t fire_idx;
    logic spk_step;
    logic spk_last;

    logic fire_now;
    logic sync_now;

    assign run_full = &run_cnt;

    // hold off new steps while a full count or a clear still has to go out
    assign net_ready = (state == IDLE) && !run_full && !clr_pend;

    assign fire_now = ctrl.en && (|net_out);
    // a sync is taken over only in a cycle where ready is shown to the dispatcher
    assign sync_now = ctrl.sync && net_ready;

    // neurons that did not fire are skipped without waiting on the stream
    assign spk_step = snk_ready || !fires[fire_idx];
    assign spk_last = (fire_idx == spk_idx_t'(NUM_OUT - 1));

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // any other packet is preceded by the steps counted so far
                if (run_full || (run_cnt != '0 && (clr_pend || fire_now || sync_now))) begin
                    next_state = RUNS;
                end else if (fire_now) begin
                    next_state = SPKS;
                end else if (clr_pend) begin
                    next_state = CLRD;
                end else if (sync_now) begin
                    next_state = SYNC;
                end
            end
            RUNS: begin
                if (snk_ready) begin
                    // a sync already taken over was requested before any clear still pending
                    if (|fires) begin
                        next_state = SPKS;
                    end else if (sync_pend) begin
                        next_state = SYNC;
                    end else if (clr_pend) begin
                        next_state = CLRD;
                    end else begin
                        next_state = IDLE;
                    end
                end
            end
            CLRD: begin
                if (snk_ready) begin
                    next_state = IDLE;
                end
            end
            SPKS: begin
                // back to idle so the firing step gets flushed before a later CLR or SNC
                if (spk_step && spk_last) begin
                    next_state = IDLE;
                end
            end
            SYNC: begin
                if (snk_ready) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            run_cnt <= '0;
        end else if (ctrl.en) begin
            run_cnt <= run_cnt + 1'b1;
        end else if (state == RUNS && snk_ready) begin
            run_cnt <= run_cnt - runs;
        end
    end

    // the snapshot tracks the counter while idle and freezes once a RUN is out
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            runs <= run_cnt;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            clr_pend <= 1'b0;
            sync_pend <= 1'b0;
        end else begin
            if (!ctrl.arstn) begin
                clr_pend <= 1'b1;
            end else if (state == CLRD && snk_ready) begin
                clr_pend <= 1'b0;
            end
            if (ctrl.sync && net_ready) begin
                sync_pend <= 1'b1;
            end else if (state == SYNC && snk_ready) begin
                sync_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            fires <= '0;
            fire_idx <= '0;
        end else begin
            if (ctrl.en) begin
                fires <= net_out;
            end else if (state == SPKS && next_state != SPKS) begin
                fires <= '0;
            end
            // walk upward so spikes leave in ascending neuron order
            if (state != SPKS) begin
                fire_idx <= '0;
            end else if (spk_step && !spk_last) begin
                fire_idx <= fire_idx + 1'b1;
            end
        end
    end

    always_comb begin
        snk = '0;
        snk_valid = 1'b0;
        case (state)
            RUNS: begin
                snk = {RUN, runs};
                snk_valid = 1'b1;
            end
            CLRD: begin
                snk = {CLR, run_t'(0)};
                snk_valid = 1'b1;
            end
            SPKS: begin
                snk = {SPK, fire_idx, {(RUN_WIDTH - SPK_WIDTH){1'b0}}};
                snk_valid = fires[fire_idx];
            end
            SYNC: begin
                snk = {SNC, run_t'(0)};
                snk_valid = 1'b1;
            end
            default: begin
                snk_valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/neuro_pkg.sv */
`default_nettype none

package neuro_pkg;

    // network size and neuron behavior
    localparam int NUM_INP = 4;
    localparam int NUM_OUT = 2;
    localparam int THRESHOLD = 2;

    // packet layout, opcode in the top bits and payload below it
    localparam int PKT_WIDTH = 8;
    localparam int NUM_OPC = 4;
    localparam int PFX_WIDTH = $clog2(NUM_OPC);
    localparam int RUN_WIDTH = PKT_WIDTH - PFX_WIDTH;
    localparam int SPK_WIDTH = $clog2(NUM_OUT);
    localparam int INP_WIDTH = $clog2(NUM_INP);

    // a potential below threshold plus every input routed to one neuron must fit
    localparam int ACC_WIDTH = $clog2(THRESHOLD + NUM_INP / NUM_OUT);

    typedef logic [PKT_WIDTH-1:0] pkt_t;
    typedef logic [RUN_WIDTH-1:0] run_t;
    typedef logic [SPK_WIDTH-1:0] spk_idx_t;
    typedef logic [INP_WIDTH-1:0] inp_idx_t;
    typedef logic [1:0] potential_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;

    typedef enum logic [PFX_WIDTH-1:0] {
        RUN,
        CLR,
        SPK,
        SNC
    } opcode_t;

    typedef struct packed {
        logic en;
        logic arstn;
        logic sync;
        logic [NUM_INP-1:0] inp;
    } net_ctrl_t;

endpackage

`default_nettype wire

/* hw/neuro_top.sv */
`timescale 1ns/1ps
`default_nettype none

module neuro_top
    import neuro_pkg::*;
(
    input  logic clk,
    input  logic arstn,
    input  pkt_t in_pkt,
    input  logic in_valid,
    output logic in_ready,
    output pkt_t snk,
    output logic snk_valid,
    input  logic snk_ready
);

    net_ctrl_t ctrl;
    logic net_ready;
    logic [NUM_OUT-1:0] net_out;

    packet_dispatch u_dispatch (
        .clk       (clk),
        .arstn     (arstn),
        .in_pkt    (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .net_ready (net_ready),
        .ctrl      (ctrl)
    );

    spiking_network u_network (
        .clk     (clk),
        .arstn   (arstn),
        .ctrl    (ctrl),
        .net_out (net_out)
    );

    // the sink sees the same control as the network so it can count steps and clears
    network_sink u_sink (
        .clk       (clk),
        .arstn     (arstn),
        .ctrl      (ctrl),
        .net_ready (net_ready),
        .net_out   (net_out),
        .snk_ready (snk_ready),
        .snk_valid (snk_valid),
        .snk       (snk)
    );

endmodule

`default_nettype wire

/* hw/packet_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_dispatch
    import neuro_pkg::*;
(
    input  logic      clk,
    input  logic      arstn,
    input  pkt_t      in_pkt,
    input  logic      in_valid,
    output logic      in_ready,
    input  logic      net_ready,
    output net_ctrl_t ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        STEP,
        CLEAR,
        SYNC
    } dispatch_state_t;

    dispatch_state_t state;

    opcode_t opc;
    run_t run_len;
    inp_idx_t inp_idx;
    logic accept;
    logic step;

    // steps still to issue for the current RUN
    run_t step_cnt;
    // input spikes waiting for the next step
    logic [NUM_INP-1:0] pend;
    // registered so the network clear is a clean single-cycle pulse
    logic clr_n;

    // field decode, the SPK index sits right below the opcode like on the output side
    assign opc = opcode_t'(in_pkt[PKT_WIDTH-1 -: PFX_WIDTH]);
    assign run_len = in_pkt[RUN_WIDTH-1:0];
    assign inp_idx = in_pkt[RUN_WIDTH-1 -: INP_WIDTH];

    assign in_ready = (state == IDLE);
    assign accept = in_valid && in_ready;

    // a step is only issued while the sink can take its result
    assign step = (state == STEP) && net_ready;

    assign ctrl.en = step;
    assign ctrl.arstn = clr_n;
    assign ctrl.sync = (state == SYNC);
    assign ctrl.inp = pend;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
            step_cnt <= '0;
            pend <= '0;
            clr_n <= 1'b1;
        end else begin
            clr_n <= 1'b1;
            case (state)
                IDLE: begin
                    if (accept) begin
                        case (opc)
                            RUN: begin
                                // RUN 0 is accepted and does nothing
                                if (run_len != '0) begin
                                    step_cnt <= run_len;
                                    state <= STEP;
                                end
                            end
                            CLR: begin
                                clr_n <= 1'b0;
                                pend <= '0;
                                state <= CLEAR;
                            end
                            SPK: begin
                                pend[inp_idx] <= 1'b1;
                            end
                            SNC: begin
                                state <= SYNC;
                            end
                            default: begin
                                state <= IDLE;
                            end
                        endcase
                    end
                end
                STEP: begin
                    if (step) begin
                        // pending spikes ride on the first step only
                        pend <= '0;
                        step_cnt <= step_cnt - 1'b1;
                        if (step_cnt == run_t'(1)) begin
                            state <= IDLE;
                        end
                    end
                end
                CLEAR: begin
                    state <= IDLE;
                end
                SYNC: begin
                    // the sink takes the request in the cycle it shows ready
                    if (net_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/spiking_network.sv */
`timescale 1ns/1ps
`default_nettype none

module spiking_network
    import neuro_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  net_ctrl_t          ctrl,
    output logic [NUM_OUT-1:0] net_out
);

    // either the global reset or a CLR from the dispatcher empties the neurons
    logic net_rstn;

    assign net_rstn = arstn & ctrl.arstn;

    genvar j;
    generate
        for (j = 0; j < NUM_OUT; j++) begin : g_neuron
            potential_t pot;
            acc_t acc;
            logic fire;

            // input i is wired to output i mod NUM_OUT with weight one
            always_comb begin
                acc = acc_t'(pot);
                for (int i = 0; i < NUM_INP; i++) begin
                    if ((i % NUM_OUT) == j && ctrl.inp[i]) begin
                        acc = acc + 1'b1;
                    end
                end
            end

            // fires in the step cycle itself so the sink can register it at the edge
            assign fire = ctrl.en && (acc >= THRESHOLD);
            assign net_out[j] = fire;

            always_ff @(posedge clk or negedge net_rstn) begin
                if (!net_rstn) begin
                    pot <= '0;
                end else if (ctrl.en) begin
                    // a firing neuron starts over from zero, there is no leak
                    if (fire) begin
                        pot <= '0;
                    end else begin
                        pot <= potential_t'(acc);
                    end
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* tb/neuro_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module neuro_checker
    import neuro_pkg::*;
(
    input logic clk,
    input logic arstn,
    input pkt_t in_pkt,
    input logic in_valid,
    input logic in_ready,
    input pkt_t snk,
    input logic snk_valid,
    input logic snk_ready
);

    int err_cnt = 0;

    // an offered output packet stays put until the consumer takes it
    snk_hold: assert property (
        @(posedge clk) disable iff (!arstn)
        snk_valid && !snk_ready |=> snk_valid && $stable(snk)
    ) else begin
        $error("snk or snk_valid changed while stalled");
        err_cnt++;
    end

    // same rule on the command side
    in_hold: assert property (
        @(posedge clk) disable iff (!arstn)
        in_valid && !in_ready |=> in_valid && $stable(in_pkt)
    ) else begin
        $error("in_pkt or in_valid changed while stalled");
        err_cnt++;
    end

    reset_quiet: assert property (
        @(posedge clk) !arstn |=> !snk_valid
    ) else begin
        $error("snk_valid high right after reset");
        err_cnt++;
    end

endmodule

bind neuro_top neuro_checker u_checker (
    .clk       (clk),
    .arstn     (arstn),
    .in_pkt    (in_pkt),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .snk       (snk),
    .snk_valid (snk_valid),
    .snk_ready (snk_ready)
);

`default_nettype wire

/* tb/neuro_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module neuro_tb
    import neuro_pkg::*;
();

    localparam int SEND_TIMEOUT = 500;
    localparam int RECV_TIMEOUT = 3000;

    logic clk;
    logic arstn;
    pkt_t in_pkt;
    logic in_valid;
    logic in_ready;
    pkt_t snk;
    logic snk_valid;
    logic snk_ready;

    // commands of the current case, the predicted stream and the merged received stream
    pkt_t cmds[$];
    pkt_t exp_pkt[$];
    int exp_total[$];
    pkt_t rx_pkt[$];
    pkt_t got_pkt[$];
    int got_total[$];

    // reference network state
    int pot[NUM_OUT];
    logic [NUM_INP-1:0] pend;
    int steps;

    neuro_top uut (
        .clk       (clk),
        .arstn     (arstn),
        .in_pkt    (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .snk       (snk),
        .snk_valid (snk_valid),
        .snk_ready (snk_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic fail_now();
        $display("Finished with errors");
        $fatal(1, "run stopped at the first failure");
    endtask

    always @(negedge clk) begin
        if (uut.u_checker.err_cnt != 0) begin
            $display("a stream property of the checker failed");
            fail_now();
        end
    end

    task automatic check_pkt(input string name, input pkt_t got, input pkt_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_total(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            fail_now();
        end
    endtask

    function automatic pkt_t run_cmd(input int n);
        return {RUN, run_t'(n)};
    endfunction

    function automatic pkt_t spk_cmd(input int i);
        return {SPK, inp_idx_t'(i), {(RUN_WIDTH - INP_WIDTH){1'b0}}};
    endfunction

    // steps counted so far go out as one run ahead of any other packet
    task automatic flush_steps();
        if (steps > 0) begin
            exp_pkt.push_back({RUN, run_t'(0)});
            exp_total.push_back(steps);
            steps = 0;
        end
    endtask

    task automatic predict_step();
        int acc[NUM_OUT];
        logic [NUM_OUT-1:0] fired;
        for (int j = 0; j < NUM_OUT; j++) begin
            acc[j] = pot[j];
        end
        for (int i = 0; i < NUM_INP; i++) begin
            if (pend[i]) begin
                acc[i % NUM_OUT] = acc[i % NUM_OUT] + 1;
            end
        end
        fired = '0;
        for (int j = 0; j < NUM_OUT; j++) begin
            fired[j] = (acc[j] >= THRESHOLD);
        end
        if (fired != '0) begin
            flush_steps();
            for (int j = 0; j < NUM_OUT; j++) begin
                if (fired[j]) begin
                    exp_pkt.push_back({SPK, spk_idx_t'(j), {(RUN_WIDTH - SPK_WIDTH){1'b0}}});
                    exp_total.push_back(0);
                end
            end
        end
        for (int j = 0; j < NUM_OUT; j++) begin
            pot[j] = fired[j] ? 0 : acc[j];
        end
        // the firing step itself belongs to the next run
        pend = '0;
        steps++;
    endtask

    task automatic queue_command(input pkt_t p);
        opcode_t op;
        int n;
        cmds.push_back(p);
        op = opcode_t'(p[PKT_WIDTH-1 -: PFX_WIDTH]);
        n = p[RUN_WIDTH-1:0];
        case (op)
            RUN: begin
                for (int k = 0; k < n; k++) begin
                    predict_step();
                end
            end
            CLR: begin
                flush_steps();
                exp_pkt.push_back({CLR, run_t'(0)});
                exp_total.push_back(0);
                pot = '{default: 0};
                pend = '0;
            end
            SPK: begin
                pend[p[RUN_WIDTH-1 -: INP_WIDTH]] = 1'b1;
            end
            default: begin
                flush_steps();
                exp_pkt.push_back({SNC, run_t'(0)});
                exp_total.push_back(0);
            end
        endcase
    endtask

    task automatic start_case();
        @(posedge clk);
        #1;
        arstn = 1'b0;
        in_valid = 1'b0;
        in_pkt = '0;
        snk_ready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arstn = 1'b1;
        cmds.delete();
        exp_pkt.delete();
        exp_total.delete();
        rx_pkt.delete();
        got_pkt.delete();
        got_total.delete();
        pot = '{default: 0};
        pend = '0;
        steps = 0;
    endtask

    task automatic drive_commands();
        int wait_cnt;
        logic accepted;
        for (int k = 0; k < cmds.size(); k++) begin
            in_pkt = cmds[k];
            in_valid = 1'b1;
            wait_cnt = 0;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
                #1;
                wait_cnt++;
                if (!accepted && wait_cnt > SEND_TIMEOUT) begin
                    $display("timed out waiting for in_ready on command %0d", k);
                    fail_now();
                end
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_stream(input int n_snc, input logic stall);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < n_snc) begin
            snk_ready = stall ? (($urandom % 3) != 0) : 1'b1;
            @(negedge clk);
            if (snk_valid && snk_ready) begin
                rx_pkt.push_back(snk);
                if (opcode_t'(snk[PKT_WIDTH-1 -: PFX_WIDTH]) == SNC) begin
                    seen++;
                end
            end
            @(posedge clk);
            #1;
            cycles++;
            if (seen < n_snc && cycles > RECV_TIMEOUT) begin
                $display("timed out waiting for output packets, %0d of %0d syncs", seen, n_snc);
                fail_now();
            end
        end
        snk_ready = 1'b1;
    endtask

    task automatic execute_case(input logic stall);
        int n_snc;
        int last;
        n_snc = 0;
        foreach (exp_pkt[k]) begin
            if (opcode_t'(exp_pkt[k][PKT_WIDTH-1 -: PFX_WIDTH]) == SNC) begin
                n_snc++;
            end
        end
        fork
            drive_commands();
            collect_stream(n_snc, stall);
        join
        // consecutive runs collapse into one step total
        foreach (rx_pkt[k]) begin
            last = got_pkt.size() - 1;
            if (opcode_t'(rx_pkt[k][PKT_WIDTH-1 -: PFX_WIDTH]) != RUN) begin
                got_pkt.push_back(rx_pkt[k]);
                got_total.push_back(0);
            end else if (last >= 0 && got_pkt[last] == {RUN, run_t'(0)}) begin
                got_total[last] = got_total[last] + rx_pkt[k][RUN_WIDTH-1:0];
            end else begin
                got_pkt.push_back({RUN, run_t'(0)});
                got_total.push_back(rx_pkt[k][RUN_WIDTH-1:0]);
            end
        end
        if (got_pkt.size() != exp_pkt.size()) begin
            $display("merged output has %0d entries, expected %0d", got_pkt.size(),
                     exp_pkt.size());
            fail_now();
        end
        foreach (exp_pkt[k]) begin
            check_pkt("snk", got_pkt[k], exp_pkt[k]);
            check_total("run total", got_total[k], exp_total[k]);
        end
        expect_quiet(6);
    endtask

    task automatic expect_quiet(input int cycles);
        snk_ready = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_bit("snk_valid", snk_valid, 1'b0);
            check_bit("in_ready", in_ready, 1'b1);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reset_behavior();
        start_case();
        expect_quiet(8);
    endtask

    task automatic run_only();
        start_case();
        queue_command(run_cmd(5));
        queue_command({SNC, run_t'(0)});
        execute_case(1'b0);
    endtask

    // inputs 0 and 2 both feed neuron 0, input 1 feeds neuron 1
    task automatic spike_routing(input logic stall);
        start_case();
        queue_command(spk_cmd(0));
        queue_command(spk_cmd(2));
        queue_command(run_cmd(3));
        queue_command({SNC, run_t'(0)});
        queue_command(spk_cmd(1));
        queue_command(run_cmd(1));
        queue_command({SNC, run_t'(0)});
        execute_case(stall);
    endtask

    task automatic clear_potentials(input logic stall);
        start_case();
        queue_command(spk_cmd(1));
        queue_command(run_cmd(1));
        queue_command({CLR, run_t'(0)});
        queue_command(spk_cmd(1));
        queue_command(run_cmd(1));
        queue_command({SNC, run_t'(0)});
        execute_case(stall);
    endtask

    task automatic count_saturation();
        start_case();
        queue_command(run_cmd(63));
        queue_command(run_cmd(63));
        queue_command({SNC, run_t'(0)});
        execute_case(1'b0);
    endtask

    initial begin
        void'($urandom(32'h71b102a2));
        arstn = 1'b0;
        in_pkt = '0;
        in_valid = 1'b0;
        snk_ready = 1'b0;
        reset_behavior();
        run_only();
        spike_routing(1'b0);
        clear_potentials(1'b0);
        count_saturation();
        spike_routing(1'b1);
        clear_potentials(1'b1);
        if (uut.u_checker.err_cnt != 0) begin
            $display("Finished with errors");
            $fatal(1, "stream checker reported failures");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
